// ==== verilog.f ====
+incdir+include
logic/plh_stream_pkg.sv
logic/plh_code_pkg.sv
logic/plsc_encoder.sv
logic/plh_serializer.sv
logic/dvb_pi_by_2_bpsk_mapper.sv
logic/plh_generator_top.sv
dv/plh_tb.sv

// ==== dv/plh_tb.sv ====
// PLHEADER generator testbench
// Directed tests of the SOF + PLSC header stream and its pi/2 BPSK
// mapping against a bit level reference model. Outputs are sampled
// on the rising edge, before the DUT registers update.

`timescale 1ns/1ps
`default_nettype none

`include "plh_macros.svh"

module plh_tb
  import plh_code_pkg::*;
  import plh_stream_pkg::*;
;

  logic      iclk;
  logic      rst_n;
  logic      iclkena;
  logic      hdr_start;
  pls_code_t pls;
  logic      busy;
  iq_sym_t   sym;

  int seed = 32'h96bd;
  int sym_errs, busy_errs, idx_errs, tmo_errs;

  plh_generator_top #(.pONE_IS_PLUS(1)) plh_generator_top_i (
    .iclk(iclk), .rst_n(rst_n), .iclkena(iclkena), .hdr_start(hdr_start),
    .pls(pls), .busy(busy), .sym(sym)
  );

  always #20 iclk = ~iclk;   // 40 ns period

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  // Bit k of the result is header symbol k
  function automatic logic [`PLH_HDR_LEN-1:0] build_hdr(input pls_code_t code);
    logic [`PLH_HDR_LEN-1:0] hb;
    logic [`PLH_SOF_LEN-1:0] sof;
    logic [63:0]             scr;
    logic                    y;
    int                      i;
    sof = `PLH_SOF_WORD;
    scr = `PLH_PLSC_SCRAMBLE;
    for (int k = 0; k < `PLH_SOF_LEN; k++) hb[k] = sof[`PLH_SOF_LEN-1-k];   // MSB first
    for (int k = 0; k < `PLH_PLSC_LEN; k++) begin
      i = k / 2;                             // Coded bit index
      y = (code[6] & i[0]) ^ (code[5] & i[1]) ^ (code[4] & i[2]) ^
          (code[3] & i[3]) ^ (code[2] & i[4]) ^ code[1];
      if (k % 2) y = y ^ code[0];            // Second of the pair
      hb[`PLH_SOF_LEN+k] = y ^ scr[63-k];
    end
    return hb;
  endfunction

  function automatic iq_sym_t expect_sym(input logic d, input int k);
    iq_sym_t s;
    logic    base;
    base  = ~d;                              // Bit 0 maps to +1
    s.sop = (k == 0);
    s.val = 1'b1;
    s.eop = (k == `PLH_HDR_LEN - 1);
    s.im  = base;
    s.re  = (k % 2 == 0) ? base : ~base;     // Odd symbols rotated
    return s;
  endfunction

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------

  task automatic check_sym(input string name, input iq_sym_t exp, input iq_sym_t act);
    if (act !== exp) begin
      sym_errs++;
      $display("Fail %s: expected sym %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_busy(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      busy_errs++;
      $display("Fail %s: expected level %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_idx(input string name, input hdr_idx_t exp, input hdr_idx_t act);
    if (act !== exp) begin
      idx_errs++;
      $display("Fail %s: expected count %0d, actual %0d", name, exp, act);
    end
  endtask

  // ----------------------------------------
  // Drivers
  // ----------------------------------------

  task automatic wait_idle(input string name);
    int to;
    to = 0;
    while (busy && to < 200) begin
      @(posedge iclk);
      to++;
    end
    if (busy) begin
      tmo_errs++;
      $display("Timeout in %s: busy never went low", name);
    end
  endtask

  // Returns right after the edge that takes the start
  task automatic send_start(input pls_code_t code);
    hdr_start <= 1'b1;
    pls       <= code;
    iclkena   <= 1'b1;
    @(posedge iclk);
    hdr_start <= 1'b0;
  endtask

  // Runs one header and checks every new valid symbol against the model
  task automatic run_header(input string name, input pls_code_t code,
                            input bit stall, input bit poke);
    logic [`PLH_HDR_LEN-1:0] hb;
    logic                    en_seen;      // Enable at the previous edge
    int                      n, extra, to, r;
    hb = build_hdr(code);
    n = 0;
    extra = 0;
    to = 0;
    wait_idle(name);
    send_start(code);
    en_seen = 1'b1;
    while (n < `PLH_HDR_LEN && to < 2000) begin
      @(posedge iclk);
      to++;
      if (en_seen && sym.val) begin
        check_sym(name, expect_sym(hb[n], n), sym);
        n++;
      end
      en_seen = iclkena;
      r = $random(seed);
      if (stall) iclkena <= r[0];          // About half the cycles
      if (poke && n == 40) begin
        hdr_start <= 1'b1;                 // Must be ignored
        pls       <= ~code;
      end else begin
        hdr_start <= 1'b0;
      end
    end
    if (n < `PLH_HDR_LEN) begin
      tmo_errs++;
      $display("Timeout in %s: header stopped after %0d symbols", name, n);
    end
    // No symbol may follow the eop
    repeat (8) begin
      @(posedge iclk);
      if (en_seen && sym.val) extra++;
      en_seen = iclkena;
      iclkena <= 1'b1;
    end
    check_idx(name, hdr_idx_t'(`PLH_HDR_LEN), hdr_idx_t'(n + extra));
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------

  task automatic test_reset();
    rst_n <= 1'b0;
    @(posedge iclk);                       // First edge clears the registers
    for (int i = 1; i < 16; i++) begin
      @(posedge iclk);
      check_busy("test_reset val", 1'b0, sym.val);
      check_busy("test_reset busy", 1'b0, busy);
    end
    rst_n <= 1'b1;
    repeat (8) begin
      @(posedge iclk);
      check_busy("test_reset val", 1'b0, sym.val);
      check_busy("test_reset busy", 1'b0, busy);
    end
  endtask

  task automatic test_sof();
    int r;
    r = $random(seed);
    run_header("test_sof", pls_code_t'(r), 1'b0, 1'b0);
  endtask

  task automatic test_plsc_codes();
    pls_code_t fixed [4] = '{7'h00, 7'h7F, 7'h2A, 7'h55};
    int        r;
    foreach (fixed[i]) run_header("test_plsc_codes", fixed[i], 1'b0, 1'b0);
    repeat (8) begin
      r = $random(seed);
      run_header("test_plsc_codes", pls_code_t'(r), 1'b0, 1'b0);
    end
  endtask

  task automatic test_latency();
    hdr_idx_t cnt;
    int       to;
    cnt = '0;
    to = 0;
    wait_idle("test_latency");
    send_start(7'h11);
    while (!(sym.val && sym.sop) && cnt < 20) begin
      @(posedge iclk);
      cnt++;
    end
    if (!(sym.val && sym.sop)) begin
      tmo_errs++;
      $display("Timeout in test_latency: no sop after the start");
    end else begin
      check_idx("test_latency", 7'd3, cnt);
    end
    check_busy("test_latency busy high", 1'b1, busy);
    while (!(sym.val && sym.eop) && to < 200) begin
      @(posedge iclk);
      to++;
    end
    if (!(sym.val && sym.eop)) begin
      tmo_errs++;
      $display("Timeout in test_latency: no eop after the sop");
    end
    check_busy("test_latency busy low", 1'b0, busy);   // Dropped with eop
  endtask

  task automatic test_busy_ignore();
    run_header("test_busy_ignore", 7'h3C, 1'b0, 1'b1);
    run_header("test_busy_ignore", 7'h43, 1'b0, 1'b0);
  endtask

  task automatic test_clkena_stall();
    run_header("test_clkena_stall", 7'h5A, 1'b1, 1'b0);
    run_header("test_clkena_stall", 7'h27, 1'b1, 1'b0);
    iclkena <= 1'b1;
  endtask

  initial begin
    iclk      = 1'b0;
    rst_n     = 1'b0;
    iclkena   = 1'b1;
    hdr_start = 1'b0;
    pls       = '0;
    test_reset();
    test_sof();
    test_plsc_codes();
    test_latency();
    test_busy_ignore();
    test_clkena_stall();
    $display("Errors: sym %0d, busy %0d, idx %0d, timeout %0d",
             sym_errs, busy_errs, idx_errs, tmo_errs);
    if (sym_errs + busy_errs + idx_errs + tmo_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/plh_generator_top.sv ====
// PLHEADER generator top
// PLSC encoder, header serializer and pi/2 BPSK mapper.
// First symbol three enabled cycles after hdr_start.

`timescale 1ns/1ps
`default_nettype none

module plh_generator_top
  import plh_code_pkg::*;
  import plh_stream_pkg::*;
#(
  parameter bit pONE_IS_PLUS = 1
)
(
  input  logic      iclk,
  input  logic      rst_n,
  input  logic      iclkena,     // Stalls the whole chain
  input  logic      hdr_start,
  input  pls_code_t pls,
  output logic      busy,
  output iq_sym_t   sym
);

  logic        plsc_load;
  plsc_word_t  plsc_word;
  bit_strobe_t hdr_bits;

  // ----------------------------------------
  // Chain
  // ----------------------------------------

  plsc_encoder plsc_encoder_i (
    .iclk      (iclk),
    .rst_n     (rst_n),
    .iclkena   (iclkena),
    .hdr_start (hdr_start),
    .pls       (pls),
    .busy      (busy),
    .plsc_load (plsc_load),
    .plsc_word (plsc_word)
  );

  plh_serializer plh_serializer_i (
    .iclk      (iclk),
    .rst_n     (rst_n),
    .iclkena   (iclkena),
    .plsc_load (plsc_load),
    .plsc_word (plsc_word),
    .busy      (busy),
    .hdr_bits  (hdr_bits)
  );

  dvb_pi_by_2_bpsk_mapper #(
    .pONE_IS_PLUS (pONE_IS_PLUS)
  ) dvb_pi_by_2_bpsk_mapper_i (
    .iclk    (iclk),
    .rst_n   (rst_n),
    .iclkena (iclkena),
    .ibits   (hdr_bits),
    .sym     (sym)
  );

endmodule

`default_nettype wire

// ==== logic/dvb_pi_by_2_bpsk_mapper.sv ====
// pi/2 BPSK mapper for DVB-S2 headers
// Even symbols: (1-2d) + j(1-2d), odd symbols: -(1-2d) + j(1-2d).
// Outputs are sign bits, polarity set by pONE_IS_PLUS.
// One cycle latency, strobes pass along with the data.

`timescale 1ns/1ps
`default_nettype none

module dvb_pi_by_2_bpsk_mapper
  import plh_stream_pkg::*;
#(
  parameter bit pONE_IS_PLUS = 1   // 1: sign bit set means +1
)
(
  input  logic        iclk,
  input  logic        rst_n,
  input  logic        iclkena,
  input  bit_strobe_t ibits,
  output iq_sym_t     sym
);

  // ----------------------------------------
  // Phase tracking
  // ----------------------------------------

  logic even_ff;            // Last symbol was even
  logic even;               // Current symbol is even
  logic base;               // Sign for an even symbol
  logic sop_q, val_q, eop_q;
  logic re_q, im_q;

  assign even = ibits.sop ? 1'b1 : !even_ff;   // Restart phase on sop
  assign base = pONE_IS_PLUS ? !ibits.dat : ibits.dat;

  // Strobes and phase
  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      sop_q   <= 1'b0;
      val_q   <= 1'b0;
      eop_q   <= 1'b0;
      even_ff <= 1'b0;      // First bit after reset counts as even
    end else if (iclkena) begin
      sop_q <= ibits.sop;
      val_q <= ibits.val;
      eop_q <= ibits.eop;
      if (ibits.val) even_ff <= even;
    end
  end

  // Sign bits, held between valid bits
  always_ff @(posedge iclk) begin
    if (iclkena && ibits.val) begin
      im_q <= base;
      re_q <= even ? base : !base;   // Odd symbols rotate by pi/2
    end
  end

  assign sym = '{sop: sop_q, val: val_q, eop: eop_q, re: re_q, im: im_q};

endmodule

`default_nettype wire

// ==== logic/plh_serializer.sv ====
// PLHEADER serializer
// Loads SOF and the scrambled PLSC word into a 90-bit shift
// register and sends it MSB first, one bit per enabled cycle,
// with sop on bit 0 and eop on bit 89. Busy while sending.

`timescale 1ns/1ps
`default_nettype none

`include "plh_macros.svh"

module plh_serializer
  import plh_code_pkg::*;
  import plh_stream_pkg::*;
(
  input  logic        iclk,
  input  logic        rst_n,
  input  logic        iclkena,
  input  logic        plsc_load,   // From encoder
  input  plsc_word_t  plsc_word,
  output logic        busy,
  output bit_strobe_t hdr_bits     // Serial header bits
);

  // ----------------------------------------
  // Declarations
  // ----------------------------------------

  ser_state_t              state;
  hdr_idx_t                idx;        // Bit being sent
  logic [`PLH_HDR_LEN-1:0] shreg;      // SOF in the upper bits
  logic                    last_sof;
  logic                    last_hdr;

  assign last_sof = (idx == hdr_idx_t'(`PLH_SOF_LEN - 1));
  assign last_hdr = (idx == hdr_idx_t'(`PLH_HDR_LEN - 1));

  // ----------------------------------------
  // FSM and bit counter
  // ----------------------------------------

  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      state <= SER_IDLE;
      idx   <= '0;
    end else if (iclkena) begin
      case (state)
        SER_IDLE: begin
          if (plsc_load) begin
            state <= SER_SOF;
            idx   <= '0;
          end
        end
        SER_SOF: begin
          idx <= idx + 1'b1;
          if (last_sof) state <= SER_PLSC;   // Bit 25 done
        end
        SER_PLSC: begin
          idx <= idx + 1'b1;
          if (last_hdr) state <= SER_IDLE;   // Bit 89 done
        end
        default: state <= SER_IDLE;
      endcase
    end
  end

  // ----------------------------------------
  // Shift register
  // ----------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (state == SER_IDLE) begin
        if (plsc_load) shreg <= {`PLH_SOF_WORD, plsc_word};
      end else begin
        shreg <= {shreg[`PLH_HDR_LEN-2:0], 1'b0};   // Next bit to MSB
      end
    end
  end

  // Outputs straight from state, the mapper adds the register
  assign busy = (state != SER_IDLE);

  assign hdr_bits = '{
    sop: busy & (idx == '0),
    val: busy,
    eop: busy & last_hdr,
    dat: shreg[`PLH_HDR_LEN-1]
  };

endmodule

`default_nettype wire

// ==== logic/plsc_encoder.sv ====
// PLSC encoder
// Takes the PLS code on an accepted start, runs the (32,6)
// biorthogonal code, doubles each bit and scrambles the 64-bit
// result. Word and load pulse come out one enabled cycle later.

`timescale 1ns/1ps
`default_nettype none

`include "plh_macros.svh"

module plsc_encoder
  import plh_code_pkg::*;
(
  input  logic       iclk,
  input  logic       rst_n,
  input  logic       iclkena,
  input  logic       hdr_start,   // One cycle start strobe
  input  pls_code_t  pls,         // Valid with hdr_start
  input  logic       busy,        // Serializer is sending a header
  output logic       plsc_load,   // One cycle, word is valid
  output plsc_word_t plsc_word
);

  // ----------------------------------------
  // Encoder function
  // ----------------------------------------

  // Bit 31 of rm is the first coded bit
  function automatic plsc_word_t encode_pls(input pls_code_t code);
    logic [31:0] rm;
    plsc_word_t  dbl;
    rm = '0;
    if (code[6]) rm = rm ^ `PLH_G_ROW1;
    if (code[5]) rm = rm ^ `PLH_G_ROW2;
    if (code[4]) rm = rm ^ `PLH_G_ROW3;
    if (code[3]) rm = rm ^ `PLH_G_ROW4;
    if (code[2]) rm = rm ^ `PLH_G_ROW5;
    if (code[1]) rm = rm ^ `PLH_G_ROW6;
    // Pair (y, y) or (y, !y)
    for (int i = 0; i < 32; i++) begin
      dbl[2*i+1] = rm[i];
      dbl[2*i]   = rm[i] ^ code[0];
    end
    return dbl ^ `PLH_PLSC_SCRAMBLE;
  endfunction

  // ----------------------------------------
  // Start acceptance
  // ----------------------------------------

  logic start_ok;

  // Ignore starts while a header is pending or running
  assign start_ok = hdr_start & ~busy & ~plsc_load;

  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      plsc_load <= 1'b0;
    end else if (iclkena) begin
      plsc_load <= start_ok;      // Pulse for one enabled cycle
    end
  end

  // Code word register, payload only
  always_ff @(posedge iclk) begin
    if (iclkena && start_ok) begin
      plsc_word <= encode_pls(pls);
    end
  end

endmodule

`default_nettype wire

// ==== logic/plh_code_pkg.sv ====
// Header content types
// PLS code, scrambled PLSC word, header symbol index and the
// serializer FSM states.

`default_nettype none

`include "plh_macros.svh"

package plh_code_pkg;

  // PLS code: MODCOD in [6:2], frame size and pilot flag in [1:0]
  // Bits 6..1 feed the encoder, bit 0 picks the doubling
  typedef logic [6:0] pls_code_t;

  typedef logic [`PLH_PLSC_LEN-1:0] plsc_word_t;   // Scrambled code word

  typedef logic [6:0] hdr_idx_t;                   // Symbol index 0..89

  // Serializer FSM
  typedef enum logic [1:0] {
    SER_IDLE = 2'd0,   // Waiting for a load
    SER_SOF  = 2'd1,   // Shifting the SOF field
    SER_PLSC = 2'd2    // Shifting the code word
  } ser_state_t;

endpackage

`default_nettype wire

// ==== logic/plh_stream_pkg.sv ====
// Symbol stream types
// Bit strobe between serializer and mapper, and the mapped
// pi/2 BPSK symbol with its frame strobes.

`default_nettype none

package plh_stream_pkg;

  // Serial header bit with frame strobes
  typedef struct packed {
    logic sop;    // First bit of header
    logic val;    // Bit valid
    logic eop;    // Last bit of header
    logic dat;
  } bit_strobe_t;

  // Mapped symbol, a set re/im bit means +1
  typedef struct packed {
    logic sop;
    logic val;
    logic eop;
    logic re;     // In-phase sign
    logic im;     // Quadrature sign
  } iq_sym_t;

endpackage

`default_nettype wire

// ==== include/plh_macros.svh ====
// DVB-S2 PLHEADER constants
// Field lengths, SOF pattern, PLSC scrambling sequence and the
// (32,6) biorthogonal generator rows. Leftmost bit goes out first.

`ifndef PLH_MACROS_SVH
`define PLH_MACROS_SVH

`define PLH_SOF_LEN        26                     // SOF length in bits
`define PLH_PLSC_LEN       64                     // PLSC length in bits
`define PLH_HDR_LEN        90                     // SOF + PLSC

`define PLH_SOF_WORD       26'h18D2E82            // Sent MSB first
`define PLH_PLSC_SCRAMBLE  64'h719D83C953422DFA   // MSB hits first code bit

// Generator rows, first coded bit is bit 31
`define PLH_G_ROW1         32'h5555_5555          // 0101...
`define PLH_G_ROW2         32'h3333_3333          // 0011...
`define PLH_G_ROW3         32'h0F0F_0F0F          // 4 zeros, 4 ones
`define PLH_G_ROW4         32'h00FF_00FF          // 8 and 8
`define PLH_G_ROW5         32'h0000_FFFF          // 16 and 16
`define PLH_G_ROW6         32'hFFFF_FFFF          // All ones

`endif
